// ==== mpm_pkg.sv ====
// Shared port counts, widths and typedefs for the mpm multiport memory, referenced by scoped name
package mpm_pkg;

  // Port counts
  parameter int num_rd_ports = 3;
  parameter int num_wr_ports = 4;
  parameter int num_drain    = 2;  // Queue entries written into storage per cycle

  // Widths
  parameter int data_width = 16;
  parameter int bank_bits  = 2;   // Four banks
  parameter int row_bits   = 4;   // Sixteen rows per bank
  parameter int addr_bits  = bank_bits + row_bits;  // Bank in the upper bits

  // Write and read data word
  typedef logic [data_width-1:0] data_t;

  // Word address, {bank, row}
  typedef logic [addr_bits-1:0] addr_t;

  typedef logic [bank_bits-1:0] bank_t;
  typedef logic [row_bits-1:0]  row_t;

endpackage

// ==== mpm_write_queue.sv ====
// Shared write queue of mpm; takes up to four writes per cycle and drains two into the bank array
`timescale 1ns/1ps

module mpm_write_queue #(
  parameter int fifo_bits = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mpm_pkg::num_wr_ports-1:0]              write,
  input  mpm_pkg::addr_t [mpm_pkg::num_wr_ports-1:0]    wr_adr,
  input  mpm_pkg::data_t [mpm_pkg::num_wr_ports-1:0]    din,
  input  logic [fifo_bits:0]                            bp_thr,
  output logic [mpm_pkg::num_wr_ports-1:0]              wr_bp,
  output logic                                          wr_overflow,
  output logic [mpm_pkg::num_drain-1:0]                 drain_vld,
  output mpm_pkg::addr_t [mpm_pkg::num_drain-1:0]       drain_adr,
  output mpm_pkg::data_t [mpm_pkg::num_drain-1:0]       drain_data
);

  localparam int depth = 1 << fifo_bits;

  mpm_pkg::addr_t q_adr  [depth];
  mpm_pkg::data_t q_data [depth];

  logic [fifo_bits-1:0] head;
  logic [fifo_bits-1:0] tail;
  logic [fifo_bits:0]   count;

  logic [fifo_bits:0]   drain_cnt;
  logic [fifo_bits:0]   free_cnt;
  logic [fifo_bits:0]   acc_cnt;
  logic [fifo_bits:0]   count_nxt;
  logic                 drop;

  logic [mpm_pkg::num_wr_ports-1:0] acc_en;
  logic [fifo_bits-1:0]             acc_slot [mpm_pkg::num_wr_ports];

  // Oldest entries go out first, at most num_drain of them
  always_comb begin
    drain_cnt = (count > (fifo_bits+1)'(mpm_pkg::num_drain)) ?
                (fifo_bits+1)'(mpm_pkg::num_drain) : count;
    for (int d = 0; d < mpm_pkg::num_drain; d++) begin
      drain_vld[d]  = count > (fifo_bits+1)'(d);
      drain_adr[d]  = q_adr[head + fifo_bits'(d)];
      drain_data[d] = q_data[head + fifo_bits'(d)];
    end
  end

  // Space freed by this edge's drain is reusable at the same edge
  assign free_cnt = (fifo_bits+1)'(depth) - (count - drain_cnt);

  // Pack accepted writes into consecutive slots in port order
  always_comb begin
    acc_cnt = '0;
    drop    = 1'b0;
    for (int i = 0; i < mpm_pkg::num_wr_ports; i++) begin
      acc_en[i]   = 1'b0;
      acc_slot[i] = tail + acc_cnt[fifo_bits-1:0];
      if (write[i]) begin
        if (acc_cnt < free_cnt) begin
          acc_en[i] = 1'b1;
          acc_cnt   = acc_cnt + 1'b1;
        end else begin
          drop = 1'b1;  // No room left
        end
      end
    end
  end

  assign count_nxt = count - drain_cnt + acc_cnt;

  always_ff @(posedge clk) begin
    for (int i = 0; i < mpm_pkg::num_wr_ports; i++) begin
      if (acc_en[i]) begin
        q_adr[acc_slot[i]]  <= wr_adr[i];
        q_data[acc_slot[i]] <= din[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      wr_overflow <= 1'b0;
    end else begin
      head        <= head + drain_cnt[fifo_bits-1:0];
      tail        <= tail + acc_cnt[fifo_bits-1:0];
      count       <= count_nxt;
      wr_overflow <= drop;  // Pulse in the cycle after the drop
    end
  end

  // Same level on every write port
  assign wr_bp = {mpm_pkg::num_wr_ports{count > bp_thr}};

endmodule

// ==== mpm_read_ports.sv ====
// Read side of mpm; grants the three read ports by bank priority and registers the requests
`timescale 1ns/1ps

module mpm_read_ports (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mpm_pkg::num_rd_ports-1:0]              read,
  input  mpm_pkg::addr_t [mpm_pkg::num_rd_ports-1:0]    rd_adr,
  output logic [mpm_pkg::num_rd_ports-1:0]              rq_vld,
  output mpm_pkg::bank_t [mpm_pkg::num_rd_ports-1:0]    rq_bank,
  output mpm_pkg::row_t  [mpm_pkg::num_rd_ports-1:0]    rq_row,
  output logic [mpm_pkg::num_rd_ports-1:0]              rd_conflict
);

  mpm_pkg::bank_t [mpm_pkg::num_rd_ports-1:0] bank;
  mpm_pkg::row_t  [mpm_pkg::num_rd_ports-1:0] row;
  logic [mpm_pkg::num_rd_ports-1:0]           grant;

  always_comb begin
    for (int i = 0; i < mpm_pkg::num_rd_ports; i++) begin
      bank[i] = rd_adr[i][mpm_pkg::addr_bits-1:mpm_pkg::row_bits];
      row[i]  = rd_adr[i][mpm_pkg::row_bits-1:0];
    end
  end

  // Lower index wins a shared bank
  always_comb begin
    for (int i = 0; i < mpm_pkg::num_rd_ports; i++) begin
      grant[i] = read[i];
      for (int j = 0; j < i; j++) begin
        if (read[j] && bank[j] == bank[i])
          grant[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rq_vld      <= '0;
      rd_conflict <= '0;
    end else begin
      rq_vld      <= grant;
      rd_conflict <= read & ~grant;  // Losers only
    end
  end

  always_ff @(posedge clk) begin
    rq_bank <= bank;
    rq_row  <= row;
  end

endmodule

// ==== mpm_bank_array.sv ====
// Banked flop storage of mpm; applies the drained writes and serves the registered reads
`timescale 1ns/1ps

module mpm_bank_array (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mpm_pkg::num_drain-1:0]                 drain_vld,
  input  mpm_pkg::addr_t [mpm_pkg::num_drain-1:0]       drain_adr,
  input  mpm_pkg::data_t [mpm_pkg::num_drain-1:0]       drain_data,
  input  logic [mpm_pkg::num_rd_ports-1:0]              rq_vld,
  input  mpm_pkg::bank_t [mpm_pkg::num_rd_ports-1:0]    rq_bank,
  input  mpm_pkg::row_t  [mpm_pkg::num_rd_ports-1:0]    rq_row,
  output logic [mpm_pkg::num_rd_ports-1:0]              rd_vld,
  output mpm_pkg::data_t [mpm_pkg::num_rd_ports-1:0]    rd_dout
);

  localparam int num_banks = 1 << mpm_pkg::bank_bits;
  localparam int num_rows  = 1 << mpm_pkg::row_bits;

  mpm_pkg::data_t mem [num_banks][num_rows];

  mpm_pkg::bank_t [mpm_pkg::num_drain-1:0] wr_bank;
  mpm_pkg::row_t  [mpm_pkg::num_drain-1:0] wr_row;

  always_comb begin
    for (int d = 0; d < mpm_pkg::num_drain; d++) begin
      wr_bank[d] = drain_adr[d][mpm_pkg::addr_bits-1:mpm_pkg::row_bits];
      wr_row[d]  = drain_adr[d][mpm_pkg::row_bits-1:0];
    end
  end

  // Later lane overrides, so lane 1 wins on a shared address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < num_banks; b++) begin
        for (int r = 0; r < num_rows; r++)
          mem[b][r] <= '0;
      end
    end else begin
      for (int d = 0; d < mpm_pkg::num_drain; d++) begin
        if (drain_vld[d])
          mem[wr_bank[d]][wr_row[d]] <= drain_data[d];
      end
    end
  end

  // Reads see storage before this edge's writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < mpm_pkg::num_rd_ports; i++) begin
      if (rq_vld[i])
        rd_dout[i] <= mem[rq_bank[i]][rq_row[i]];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rd_vld <= '0;
    else
      rd_vld <= rq_vld;
  end

endmodule

// ==== mpm_top.sv ====
// Top level of the mpm three-read four-write memory; connects write queue, read ports and banks
`timescale 1ns/1ps

module mpm_top #(
  parameter int fifo_bits = 4  // Queue depth is 2**fifo_bits
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mpm_pkg::num_wr_ports-1:0]              write,
  input  mpm_pkg::addr_t [mpm_pkg::num_wr_ports-1:0]    wr_adr,
  input  mpm_pkg::data_t [mpm_pkg::num_wr_ports-1:0]    din,
  input  logic [fifo_bits:0]                            bp_thr,
  output logic [mpm_pkg::num_wr_ports-1:0]              wr_bp,
  output logic                                          wr_overflow,
  input  logic [mpm_pkg::num_rd_ports-1:0]              read,
  input  mpm_pkg::addr_t [mpm_pkg::num_rd_ports-1:0]    rd_adr,
  output logic [mpm_pkg::num_rd_ports-1:0]              rd_vld,
  output mpm_pkg::data_t [mpm_pkg::num_rd_ports-1:0]    rd_dout,
  output logic [mpm_pkg::num_rd_ports-1:0]              rd_conflict
);

  logic [mpm_pkg::num_drain-1:0]              drain_vld;
  mpm_pkg::addr_t [mpm_pkg::num_drain-1:0]    drain_adr;
  mpm_pkg::data_t [mpm_pkg::num_drain-1:0]    drain_data;

  logic [mpm_pkg::num_rd_ports-1:0]           rq_vld;
  mpm_pkg::bank_t [mpm_pkg::num_rd_ports-1:0] rq_bank;
  mpm_pkg::row_t  [mpm_pkg::num_rd_ports-1:0] rq_row;

  mpm_write_queue #(.fifo_bits(fifo_bits)) wq_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .bp_thr      (bp_thr),
    .wr_bp       (wr_bp),
    .wr_overflow (wr_overflow),
    .drain_vld   (drain_vld),
    .drain_adr   (drain_adr),
    .drain_data  (drain_data)
  );

  mpm_read_ports rp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .read        (read),
    .rd_adr      (rd_adr),
    .rq_vld      (rq_vld),
    .rq_bank     (rq_bank),
    .rq_row      (rq_row),
    .rd_conflict (rd_conflict)
  );

  mpm_bank_array ba_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .drain_vld  (drain_vld),
    .drain_adr  (drain_adr),
    .drain_data (drain_data),
    .rq_vld     (rq_vld),
    .rq_bank    (rq_bank),
    .rq_row     (rq_row),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout)
  );

endmodule

// ==== mpm_asserts.sv ====
// Assertion checker bound into the mpm write queue and read ports; unused inputs are tied to zero
`timescale 1ns/1ps

module mpm_asserts #(
  parameter int fifo_bits = 4
) (
  input logic                                       clk,
  input logic                                       rst_n,
  input logic [fifo_bits:0]                         count,
  input logic [fifo_bits:0]                         count_nxt,
  input logic [fifo_bits:0]                         bp_thr,
  input logic [mpm_pkg::num_wr_ports-1:0]           wr_bp,
  input logic [mpm_pkg::num_rd_ports-1:0]           rq_vld,
  input mpm_pkg::bank_t [mpm_pkg::num_rd_ports-1:0] rq_bank
);

  localparam int depth = 1 << fifo_bits;

  int unsigned fails = 0;
  logic        bank_clash;

  // Two granted requests on one bank
  always_comb begin
    bank_clash = 1'b0;
    for (int i = 0; i < mpm_pkg::num_rd_ports; i++) begin
      for (int j = 0; j < i; j++) begin
        if (rq_vld[i] && rq_vld[j] && rq_bank[i] == rq_bank[j])
          bank_clash = 1'b1;
      end
    end
  end

  count_bound: assert property (@(posedge clk) disable iff (!rst_n) count <= depth)
    else begin
      $error("Write queue count exceeds the depth");
      fails++;
    end

  // Level follows the count loaded at the previous edge, no extra stage
  bp_level: assert property (@(posedge clk) disable iff (!rst_n)
                             $past(rst_n) |->
                             wr_bp == {mpm_pkg::num_wr_ports{$past(count_nxt) > bp_thr}})
    else begin
      $error("wr_bp does not match count above threshold");
      fails++;
    end

  bank_unique: assert property (@(posedge clk) disable iff (!rst_n) !bank_clash)
    else begin
      $error("Granted read requests share a bank");
      fails++;
    end

endmodule

bind mpm_write_queue mpm_asserts #(.fifo_bits(fifo_bits)) wq_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .count     (count),
  .count_nxt (count_nxt),
  .bp_thr    (bp_thr),
  .wr_bp     (wr_bp),
  .rq_vld    ('0),
  .rq_bank   ('0)
);

bind mpm_read_ports mpm_asserts rp_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .count     ('0),
  .count_nxt ('0),
  .bp_thr    ('0),
  .wr_bp     ('0),
  .rq_vld    (rq_vld),
  .rq_bank   (rq_bank)
);

// ==== mpm_tb.sv ====
// Testbench for mpm_top; LCG traffic checked against a queue, memory and read pipeline model
`timescale 1ns/1ps

module mpm_tb;

  localparam int fifo_bits     = 4;
  localparam int depth         = 1 << fifo_bits;
  localparam int run_cycles    = 4 + 64 + 24 + 50 + 30 + 310;  // Reset plus all phases
  localparam int timeout_limit = run_cycles + 50;

  logic                                       clk;
  logic                                       rst_n;
  logic [mpm_pkg::num_wr_ports-1:0]           write;
  mpm_pkg::addr_t [mpm_pkg::num_wr_ports-1:0] wr_adr;
  mpm_pkg::data_t [mpm_pkg::num_wr_ports-1:0] din;
  logic [fifo_bits:0]                         bp_thr;
  logic [mpm_pkg::num_wr_ports-1:0]           wr_bp;
  logic                                       wr_overflow;
  logic [mpm_pkg::num_rd_ports-1:0]           read;
  mpm_pkg::addr_t [mpm_pkg::num_rd_ports-1:0] rd_adr;
  logic [mpm_pkg::num_rd_ports-1:0]           rd_vld;
  mpm_pkg::data_t [mpm_pkg::num_rd_ports-1:0] rd_dout;
  logic [mpm_pkg::num_rd_ports-1:0]           rd_conflict;

  // Reference model
  mpm_pkg::addr_t                   q_adr [$];
  mpm_pkg::data_t                   q_data [$];
  mpm_pkg::data_t                   ref_mem [1 << mpm_pkg::addr_bits];
  logic [mpm_pkg::num_rd_ports-1:0] s1_vld;
  mpm_pkg::addr_t                   s1_adr [mpm_pkg::num_rd_ports];
  logic [mpm_pkg::num_rd_ports-1:0] exp_vld;
  logic [mpm_pkg::num_rd_ports-1:0] exp_conf;
  mpm_pkg::data_t                   exp_dout [mpm_pkg::num_rd_ports];
  logic                             exp_ovf;

  logic [31:0]    seed = 32'hff50_de97;
  logic [31:0]    r;
  mpm_pkg::addr_t hist [4];
  int             errors;
  int             checks;
  int             assert_fails;
  int             cycles;

  mpm_top #(.fifo_bits(fifo_bits)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the test did not finish within %0d cycles", timeout_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_outputs();
    logic [mpm_pkg::num_wr_ports-1:0] exp_bp;
    exp_bp = (q_adr.size() > bp_thr) ? '1 : '0;
    compare("wr_bp", exp_bp, wr_bp);
    compare("wr_overflow", exp_ovf, wr_overflow);
    compare("rd_vld", exp_vld, rd_vld);
    compare("rd_conflict", exp_conf, rd_conflict);
    for (int p = 0; p < mpm_pkg::num_rd_ports; p++) begin
      if (exp_vld[p])
        compare($sformatf("rd_dout[%0d]", p), exp_dout[p], rd_dout[p]);
    end
  endtask

  // One rising edge of the model, using the inputs driven for it
  task automatic model_edge();
    logic [mpm_pkg::num_rd_ports-1:0] grant;
    mpm_pkg::addr_t                   a;
    int                               n;
    exp_vld = s1_vld;
    for (int p = 0; p < mpm_pkg::num_rd_ports; p++) begin
      if (s1_vld[p])
        exp_dout[p] = ref_mem[s1_adr[p]];  // Storage before this edge's drains
    end
    for (int p = 0; p < mpm_pkg::num_rd_ports; p++) begin
      grant[p] = read[p];
      for (int j = 0; j < p; j++) begin
        if (read[j] && (rd_adr[j] >> mpm_pkg::row_bits) == (rd_adr[p] >> mpm_pkg::row_bits))
          grant[p] = 1'b0;
      end
      s1_adr[p] = rd_adr[p];
    end
    exp_conf = read & ~grant;
    s1_vld   = grant;
    // Oldest first, so the younger lane lands last
    n = (q_adr.size() > mpm_pkg::num_drain) ? mpm_pkg::num_drain : q_adr.size();
    for (int d = 0; d < n; d++) begin
      a = q_adr.pop_front();
      ref_mem[a] = q_data.pop_front();
    end
    exp_ovf = 1'b0;
    for (int i = 0; i < mpm_pkg::num_wr_ports; i++) begin
      if (write[i] && q_adr.size() < depth) begin
        q_adr.push_back(wr_adr[i]);
        q_data.push_back(din[i]);
      end else if (write[i]) begin
        exp_ovf = 1'b1;
      end
    end
  endtask

  task automatic advance();
    model_edge();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic clear_strobes();
    write = '0;
    read  = '0;
  endtask

  initial begin
    rst_n    = 1'b0;
    write    = '0;
    wr_adr   = '0;
    din      = '0;
    bp_thr   = '0;
    read     = '0;
    rd_adr   = '0;
    errors   = 0;
    checks   = 0;
    s1_vld   = '0;
    exp_vld  = '0;
    exp_conf = '0;
    exp_ovf  = 1'b0;
    foreach (ref_mem[a]) ref_mem[a] = '0;
    foreach (exp_dout[p]) begin
      exp_dout[p] = '0;
      s1_adr[p]   = '0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_outputs();

    // Storage is all zero after reset
    for (int i = 0; i < 64; i++) begin
      clear_strobes();
      read      = '1;
      rd_adr[0] = mpm_pkg::addr_t'(i);
      rd_adr[1] = mpm_pkg::addr_t'(63 - i);
      rd_adr[2] = mpm_pkg::addr_t'(i + 21);
      advance();
    end

    // Single writes, each read back two cycles later
    for (int i = 0; i < 24; i++) begin
      clear_strobes();
      r = next_rand();
      hist[i % 4]    = r[5:0];
      write[i % 4]   = 1'b1;
      wr_adr[i % 4]  = r[5:0];
      din[i % 4]     = r[31:16];
      if (i >= 2) begin
        read[0]   = 1'b1;
        rd_adr[0] = hist[(i - 2) % 4];
      end
      advance();
    end

    // Bursts on all write ports fill the queue past the threshold
    r      = next_rand();
    bp_thr = (fifo_bits+1)'(r % depth);
    for (int i = 0; i < 50; i++) begin
      clear_strobes();
      if (i < 40) begin
        write = '1;
        for (int p = 0; p < mpm_pkg::num_wr_ports; p++) begin
          r         = next_rand();
          wr_adr[p] = r[5:0];
          din[p]    = r[31:16];
        end
      end
      advance();
    end

    // Three reads at once, alternating distinct banks and one shared bank
    for (int i = 0; i < 30; i++) begin
      clear_strobes();
      read = '1;
      r    = next_rand();
      for (int p = 0; p < mpm_pkg::num_rd_ports; p++) begin
        if (i % 2 == 0)
          rd_adr[p] = {mpm_pkg::bank_t'(p + i), mpm_pkg::row_t'(r >> (4 * p))};
        else
          rd_adr[p] = {mpm_pkg::bank_t'(r[1:0]), mpm_pkg::row_t'(r >> (4 * p + 8))};
      end
      advance();
    end

    // Mixed traffic on a narrow address set, so drains and reads collide
    r      = next_rand();
    bp_thr = (fifo_bits+1)'(r % (depth + 1));
    for (int i = 0; i < 310; i++) begin
      clear_strobes();
      if (i < 300) begin
        for (int p = 0; p < mpm_pkg::num_wr_ports; p++) begin
          r         = next_rand();
          write[p]  = r[2:0] < 3'd3;
          wr_adr[p] = r[13:8] & 6'h33;
          din[p]    = r[31:16];
        end
        for (int p = 0; p < mpm_pkg::num_rd_ports; p++) begin
          r         = next_rand();
          read[p]   = r[0];
          rd_adr[p] = r[13:8] & 6'h33;
        end
      end
      advance();
    end

    assert_fails = dut_i.wq_i.wq_chk.fails + dut_i.rp_i.rp_chk.fails;
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
mpm_pkg.sv
mpm_write_queue.sv
mpm_read_ports.sv
mpm_bank_array.sv
mpm_top.sv
mpm_asserts.sv
mpm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mpm testbench with Verilator; exit status follows the test result
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f all.f --top-module mpm_tb -Mdir obj_dir -o mpm_sim &&
out=$(./obj_dir/mpm_sim +verilator+error+limit+1000) ; echo "$out" ;
echo "$out" | grep -q "ALL TESTS PASSED" && echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }
